/* Bender.yml */
package:
  name: m1_subsys

sources:
  - files:
      - verilog/m1_pkg.sv
      - verilog/m1_mmu_cfg.sv
      - verilog/m1_prefetch_buf.sv
      - verilog/m1_mmu.sv
      - verilog/m1_wb_mem.sv
      - verilog/m1_subsys.sv
  - target: simulation
    files:
      - dv/tb_m1_subsys.sv

/* dv/m1_stimulus.txt */
# op addr data sel exp_a exp_b, fields after the op letter in hex
# C addr=register code data=write value, I exp_a=fetch word, R/W data read or written
# B addr=fetch address data=data read address exp_a=fetch word exp_b=data word
# Window still off, fetches go to external RAM
W 00000100 11223344 f 00000000 00000000
I 00000100 00000000 0 11223344 00000000
W 00000200 a5a5a5a5 f 00000000 00000000
R 00000200 00000000 f a5a5a5a5 00000000
# Load buffer words 16..19, then base 0x2000 and enable
C 00000002 00000010 0 00000000 00000000
C 00000003 cafe0000 0 00000000 00000000
C 00000003 cafe0001 0 00000000 00000000
C 00000003 cafe0002 0 00000000 00000000
C 00000003 cafe0003 0 00000000 00000000
C 00000002 000000ff 0 00000000 00000000
C 00000003 deadbeef 0 00000000 00000000
C 00000003 feedface 0 00000000 00000000
C 00000001 00002000 0 00000000 00000000
C 00000000 00000001 0 00000000 00000000
I 00002040 00000000 0 cafe0000 00000000
I 00002044 00000000 0 cafe0001 00000000
I 00002048 00000000 0 cafe0002 00000000
I 0000204c 00000000 0 cafe0003 00000000
I 000023fc 00000000 0 deadbeef 00000000
I 00002000 00000000 0 feedface 00000000
# Outside the window, same low index as buffer words
W 00000040 0badf00d f 00000000 00000000
I 00000040 00000000 0 0badf00d 00000000
W 00003044 12345678 f 00000000 00000000
I 00003044 00000000 0 12345678 00000000
# Byte-lane merges
W 00000300 00000000 f 00000000 00000000
W 00000300 aabbccdd 5 00000000 00000000
R 00000300 00000000 f 00bb00dd 00000000
W 00000300 11223344 8 00000000 00000000
R 00000300 00000000 f 11bb00dd 00000000
W 00000300 55667788 2 00000000 00000000
R 00000300 00000000 f 11bb77dd 00000000
# Fetch and data read at once
B 00000100 00000200 0 11223344 a5a5a5a5
B 00003044 00000300 0 12345678 11bb77dd
B 00002048 00000040 0 cafe0002 0badf00d
# Base moved to 0, old hit address now misses
C 00000001 00000000 0 00000000 00000000
I 00002040 00000000 0 0badf00d 00000000
I 00000040 00000000 0 cafe0000 00000000
C 00000000 00000000 0 00000000 00000000
I 00000040 00000000 0 0badf00d 00000000

/* dv/tb_m1_subsys.sv */
module tb_m1_subsys import m1_pkg::*; ();

  logic              sys_clock;
  logic              reset;
  logic              cfg_we;
  logic [CFG_AW-1:0] cfg_addr;
  logic [M1_DW-1:0]  cfg_wdata;
  logic              imem_read;
  logic [M1_AW-1:0]  imem_addr;
  logic              imem_done;
  logic [M1_DW-1:0]  imem_data;
  logic              dmem_read;
  logic              dmem_write;
  logic [M1_AW-1:0]  dmem_addr;
  logic [M1_DW-1:0]  dmem_data;
  logic [M1_SW-1:0]  dmem_sel;
  logic              dmem_done;
  logic [M1_DW-1:0]  dmem_rdata;

  // Operations from the stimulus file, one entry per line
  byte               op_q[$];
  logic [31:0]       addr_q[$];
  logic [31:0]       data_q[$];
  logic [31:0]       sel_q[$];
  logic [31:0]       expa_q[$];
  logic [31:0]       expb_q[$];
  bit                ops_ready = 1'b0;              // Watchdog starts once ops are known

  // Reference view of the window, follows config writes
  logic                      win_en_m;
  logic [M1_AW-1:PF_WIN_LSB] win_base_m;

  m1_subsys m1_subsys_i (
    .sys_clock_i  (sys_clock),
    .reset_i      (reset),
    .cfg_we_i     (cfg_we),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .imem_read_i  (imem_read),
    .imem_addr_i  (imem_addr),
    .imem_done_o  (imem_done),
    .imem_data_o  (imem_data),
    .dmem_read_i  (dmem_read),
    .dmem_write_i (dmem_write),
    .dmem_addr_i  (dmem_addr),
    .dmem_data_i  (dmem_data),
    .dmem_sel_i   (dmem_sel),
    .dmem_done_o  (dmem_done),
    .dmem_data_o  (dmem_rdata)
  );

  initial begin
    sys_clock = 1'b0;
    forever #20 sys_clock = ~sys_clock;             // Period 40
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Hit rule, enabled window and matching upper address bits
  function automatic bit in_window(input logic [M1_AW-1:0] addr);
    return win_en_m && (addr[M1_AW-1:PF_WIN_LSB] == win_base_m);
  endfunction

  task automatic read_stimulus();
    int          fd;
    int          c;
    int          n;
    logic [31:0] f_addr, f_data, f_sel, f_exp_a, f_exp_b;
    fd = $fopen("dv/m1_stimulus.txt", "r");
    if (fd == 0) begin
      $display("The stimulus file dv/m1_stimulus.txt could not be opened");
      $display("Checks failed");
      $fatal(1, "no stimulus");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != -1 && c != "\n") begin        // Skip comment to end of line
          c = $fgetc(fd);
        end
      end else if (c == "C" || c == "I" || c == "R" || c == "W" || c == "B") begin
        n = $fscanf(fd, "%h %h %h %h %h", f_addr, f_data, f_sel, f_exp_a, f_exp_b);
        if (n != 5) begin
          $display("Stimulus line for op %c is missing fields", c[7:0]);
          $display("Checks failed");
          $fatal(1, "bad stimulus line");
        end
        op_q.push_back(c[7:0]);
        addr_q.push_back(f_addr);
        data_q.push_back(f_data);
        sel_q.push_back(f_sel);
        expa_q.push_back(f_exp_a);
        expb_q.push_back(f_exp_b);
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        $display("Unknown op code %c in the stimulus file", c[7:0]);
        $display("Checks failed");
        $fatal(1, "bad op code");
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // Sample at negedge, drop each finished level on the following posedge
  task automatic wait_done(input bit want_i, input bit want_d,
                           output int i_cyc, output int d_cyc,
                           output logic [M1_DW-1:0] i_word, output logic [M1_DW-1:0] d_word);
    int cyc;
    bit i_pend;
    bit d_pend;
    cyc    = 0;                                     // Request cycle counts as 0
    i_pend = want_i;
    d_pend = want_d;
    i_cyc  = -1;
    d_cyc  = -1;
    i_word = '0;
    d_word = '0;
    while (i_pend || d_pend) begin
      @(negedge sys_clock);
      if (d_pend && dmem_done) begin
        d_word = dmem_rdata;
        d_cyc  = cyc;
        d_pend = 1'b0;
      end
      if (i_pend && imem_done) begin
        i_word = imem_data;
        i_cyc  = cyc;
        i_pend = 1'b0;
      end
      @(posedge sys_clock);
      if (!d_pend) begin
        dmem_read  <= 1'b0;
        dmem_write <= 1'b0;
      end
      if (!i_pend) imem_read <= 1'b0;
      cyc++;
    end
  endtask

  initial begin : watchdog
    wait (ops_ready);
    // 20 cycles per operation plus reset margin
    repeat ((op_q.size() + 10) * 20) @(posedge sys_clock);
    $display("Simulation timed out before all operations completed");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int               i_cyc, d_cyc;
    logic [M1_DW-1:0] i_word, d_word;
    bit               hit;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    imem_read  = 1'b0;
    imem_addr  = '0;
    dmem_read  = 1'b0;
    dmem_write = 1'b0;
    dmem_addr  = '0;
    dmem_data  = '0;
    dmem_sel   = '0;
    reset      = 1'b1;
    win_en_m   = 1'b0;                              // Reset state of the window
    win_base_m = '0;
    read_stimulus();
    ops_ready = 1'b1;
    repeat (5) @(posedge sys_clock);                // Reset for 5 cycles
    reset <= 1'b0;

    for (int k = 0; k < op_q.size(); k++) begin
      @(posedge sys_clock);
      hit = in_window(addr_q[k]);
      case (op_q[k])
        "C": begin
          cfg_we    <= 1'b1;                        // One-cycle strobe
          cfg_addr  <= addr_q[k][CFG_AW-1:0];
          cfg_wdata <= data_q[k];
          @(posedge sys_clock);
          cfg_we <= 1'b0;
          if (addr_q[k][CFG_AW-1:0] == CFG_CTRL) win_en_m = data_q[k][0];
          if (addr_q[k][CFG_AW-1:0] == CFG_BASE) win_base_m = data_q[k][M1_AW-1:PF_WIN_LSB];
        end
        "I": begin
          imem_read <= 1'b1;
          imem_addr <= addr_q[k];
          wait_done(1'b1, 1'b0, i_cyc, d_cyc, i_word, d_word);
          check_eq(i_word, expa_q[k], $sformatf("op %0d fetch data", k));
          // Hit in the request cycle, miss after grant plus ack delay
          check_eq(i_cyc, hit ? 0 : WB_ACK_DELAY, $sformatf("op %0d fetch latency", k));
        end
        "R", "W": begin
          dmem_read  <= (op_q[k] == "R");
          dmem_write <= (op_q[k] == "W");
          dmem_addr  <= addr_q[k];
          dmem_data  <= data_q[k];
          dmem_sel   <= sel_q[k][M1_SW-1:0];
          wait_done(1'b0, 1'b1, i_cyc, d_cyc, i_word, d_word);
          if (op_q[k] == "R") check_eq(d_word, expa_q[k], $sformatf("op %0d read data", k));
          check_eq(d_cyc, WB_ACK_DELAY, $sformatf("op %0d data latency", k));
        end
        default: begin                              // B, fetch and data read together
          imem_read <= 1'b1;
          imem_addr <= addr_q[k];
          dmem_read <= 1'b1;
          dmem_addr <= data_q[k];
          dmem_sel  <= '1;
          wait_done(1'b1, 1'b1, i_cyc, d_cyc, i_word, d_word);
          check_eq(i_word, expa_q[k], $sformatf("op %0d joint fetch data", k));
          check_eq(d_word, expb_q[k], $sformatf("op %0d joint read data", k));
          check_eq(d_cyc, WB_ACK_DELAY, $sformatf("op %0d joint data latency", k));
          if (hit) check_eq(i_cyc, 0, $sformatf("op %0d joint hit latency", k));
          else check_eq(d_cyc <= i_cyc, 1, $sformatf("op %0d data before fetch", k));
        end
      endcase
    end

    if (op_q.size() == 0) begin
      $display("The stimulus file held no operations");
      $display("Checks failed");
      $fatal(1, "empty stimulus");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

/* project.f */
verilog/m1_pkg.sv
verilog/m1_mmu_cfg.sv
verilog/m1_prefetch_buf.sv
verilog/m1_mmu.sv
verilog/m1_wb_mem.sv
verilog/m1_subsys.sv
dv/tb_m1_subsys.sv

/* verilog/m1_mmu.sv */
module m1_mmu import m1_pkg::*; (
  // System
  input  logic                      sys_clock_i,  // System clock
  input  logic                      reset_i,      // Sync reset, active high

  // Window settings
  input  logic                      win_en_i,     // Window enable
  input  logic [M1_AW-1:PF_WIN_LSB] win_base_i,   // Window base

  // Instruction request
  input  logic                      imem_read_i,  // Fetch level, held until done
  input  logic [M1_AW-1:0]          imem_addr_i,  // Fetch address
  output logic                      imem_done_o,  // Fetch done
  output logic [M1_DW-1:0]          imem_data_o,  // Fetched word

  // Data request
  input  logic                      dmem_read_i,  // Read level, held until done
  input  logic                      dmem_write_i, // Write level, held until done
  input  logic [M1_AW-1:0]          dmem_addr_i,  // Data address
  input  logic [M1_DW-1:0]          dmem_data_i,  // Write data
  input  logic [M1_SW-1:0]          dmem_sel_i,   // Byte selects
  output logic                      dmem_done_o,  // Data done
  output logic [M1_DW-1:0]          dmem_data_o,  // Read data

  // Prefetch buffer read port
  output logic [PF_IDX_W-1:0]       pf_rd_idx_o,  // Word index into buffer
  input  logic [M1_DW-1:0]          pf_rd_data_i, // Buffer word

  // Wishbone master
  output logic                      wb_cyc_o,     // Cycle
  output logic                      wb_stb_o,     // Strobe
  output logic                      wb_we_o,      // Write enable
  output logic [M1_AW-1:0]          wb_adr_o,     // Address
  output logic [M1_DW-1:0]          wb_dat_o,     // Write data
  output logic [M1_SW-1:0]          wb_sel_o,     // Byte selects
  input  logic                      wb_ack_i,     // Acknowledge
  input  logic [M1_DW-1:0]          wb_dat_i      // Read data
);

  // Request decode
  logic win_hit;                                  // Fetch falls in the window
  logic imem_ext_req;                             // Fetch needs the bus
  logic dmem_req;                                 // Data access pending

  // Bus ownership
  logic own_i_q;                                  // Instruction miss holds the bus
  logic own_d_q;                                  // Data access holds the bus
  logic bus_idle;
  logic grant_i;                                  // New grant this cycle
  logic grant_d;
  logic sel_i;                                    // Effective owner, latched or new
  logic sel_d;

  // Window compare on the upper address bits
  assign win_hit = win_en_i && (imem_addr_i[M1_AW-1:PF_WIN_LSB] == win_base_i);

  assign imem_ext_req = imem_read_i && !win_hit;
  assign dmem_req     = dmem_read_i || dmem_write_i;

  // Buffer index, the word offset inside the window
  assign pf_rd_idx_o = imem_addr_i[PF_WIN_LSB-1:PF_WIN_LSB-PF_IDX_W];

  // Grant only from idle, data first
  assign bus_idle = !own_i_q && !own_d_q;
  assign grant_d  = bus_idle && dmem_req;
  assign grant_i  = bus_idle && imem_ext_req && !dmem_req;

  // Grant counts in the request cycle, so no dead cycle before strobe
  assign sel_d = own_d_q || grant_d;
  assign sel_i = own_i_q || grant_i;

  // Owner held until ack, then released on that edge
  always_ff @(posedge sys_clock_i) begin
    if (reset_i) begin
      own_i_q <= 1'b0;
      own_d_q <= 1'b0;
    end else if (wb_ack_i) begin
      own_i_q <= 1'b0;
      own_d_q <= 1'b0;
    end else begin
      if (grant_d) begin
        own_d_q <= 1'b1;
      end
      if (grant_i) begin
        own_i_q <= 1'b1;
      end
    end
  end

  // Bus steering
  assign wb_cyc_o = sel_i || sel_d;
  assign wb_stb_o = sel_i || sel_d;               // No pipelining, stb follows cyc
  assign wb_we_o  = sel_d && dmem_write_i;        // Fetches never write
  assign wb_adr_o = sel_d ? dmem_addr_i : imem_addr_i;
  assign wb_dat_o = dmem_data_i;
  assign wb_sel_o = sel_d ? dmem_sel_i : {M1_SW{1'b1}}; // Miss reads whole word

  // Completion routing, ack goes to the owner only
  assign imem_done_o = (imem_read_i && win_hit) || (sel_i && wb_ack_i);
  assign dmem_done_o = sel_d && wb_ack_i;

  // Return data
  assign imem_data_o = win_hit ? pf_rd_data_i : wb_dat_i;
  assign dmem_data_o = wb_dat_i;

endmodule

/* verilog/m1_mmu_cfg.sv */
module m1_mmu_cfg import m1_pkg::*; (
  // System
  input  logic                      sys_clock_i,  // System clock
  input  logic                      reset_i,      // Sync reset, active high

  // Config write port
  input  logic                      cfg_we_i,     // One-cycle write strobe
  input  logic [CFG_AW-1:0]         cfg_addr_i,   // Register code
  input  logic [M1_DW-1:0]          cfg_wdata_i,  // Write data

  // Window settings towards the MMU
  output logic                      win_en_o,     // Window enable
  output logic [M1_AW-1:PF_WIN_LSB] win_base_o,   // Window base, upper address bits

  // Load port towards the prefetch buffer
  output logic                      pf_load_o,    // Load strobe
  output logic [PF_IDX_W-1:0]       pf_idx_o,     // Word index to load
  output logic [M1_DW-1:0]          pf_data_o     // Word to load
);

  // Control state
  logic                      win_en_q;
  logic [M1_AW-1:PF_WIN_LSB] win_base_q;
  logic [PF_IDX_W-1:0]       ld_ptr_q;            // Auto-incrementing load pointer

  // Per-register write decodes
  logic wr_ctrl;
  logic wr_base;
  logic wr_ldptr;
  logic wr_lddata;

  assign wr_ctrl   = cfg_we_i && (cfg_addr_i == CFG_CTRL);
  assign wr_base   = cfg_we_i && (cfg_addr_i == CFG_BASE);
  assign wr_ldptr  = cfg_we_i && (cfg_addr_i == CFG_LDPTR);
  assign wr_lddata = cfg_we_i && (cfg_addr_i == CFG_LDDATA);

  always_ff @(posedge sys_clock_i) begin
    if (reset_i) begin
      win_en_q   <= 1'b0;                         // Window off after reset
      win_base_q <= '0;
      ld_ptr_q   <= '0;
    end else begin
      if (wr_ctrl) begin
        win_en_q <= cfg_wdata_i[0];
      end
      if (wr_base) begin
        win_base_q <= cfg_wdata_i[M1_AW-1:PF_WIN_LSB]; // Low bits ignored
      end
      // Explicit pointer write beats the increment
      if (wr_ldptr) begin
        ld_ptr_q <= cfg_wdata_i[PF_IDX_W-1:0];
      end else if (wr_lddata) begin
        ld_ptr_q <= ld_ptr_q + 1'b1;              // Wraps at PF_DEPTH
      end
    end
  end

  assign win_en_o   = win_en_q;
  assign win_base_o = win_base_q;

  // Buffer write lands on the same edge as the pointer bump
  assign pf_load_o = wr_lddata;
  assign pf_idx_o  = ld_ptr_q;                    // Current pointer, pre-increment
  assign pf_data_o = cfg_wdata_i;

endmodule

/* verilog/m1_pkg.sv */
package m1_pkg;

  // Bus widths
  localparam int M1_AW = 32;                  // Address width
  localparam int M1_DW = 32;                  // Data width
  localparam int M1_SW = M1_DW / 8;           // Byte selects, one per byte lane

  // Prefetch buffer geometry, 256 words = 1 KB window
  localparam int PF_DEPTH = 256;
  localparam int PF_IDX_W = 8;                // Word index, address bits [9:2]
  localparam int PF_WIN_LSB = 10;             // Window base compares bits [31:10]

  // Config register file
  localparam int CFG_AW = 2;
  localparam logic [CFG_AW-1:0] CFG_CTRL   = 2'd0; // Bit 0 enables the window
  localparam logic [CFG_AW-1:0] CFG_BASE   = 2'd1; // Window base, bits [31:10]
  localparam logic [CFG_AW-1:0] CFG_LDPTR  = 2'd2; // Buffer load pointer, word index
  localparam logic [CFG_AW-1:0] CFG_LDDATA = 2'd3; // Load word at pointer, then bump

  // External slave timing
  localparam int WB_ACK_DELAY = 2;            // Cycles from first strobe to ack
  localparam int WB_CNT_W = $clog2(WB_ACK_DELAY + 1); // Delay counter width

  // External RAM geometry, 1024 words, address bits [11:2]
  localparam int EXT_DEPTH = 1024;
  localparam int EXT_IDX_W = 10;

endpackage

/* verilog/m1_prefetch_buf.sv */
module m1_prefetch_buf import m1_pkg::*; (
  input  logic                sys_clock_i,        // System clock

  // Load port from the config block
  input  logic                pf_load_i,          // Write strobe
  input  logic [PF_IDX_W-1:0] pf_idx_i,           // Write word index
  input  logic [M1_DW-1:0]    pf_data_i,          // Write data

  // Fetch read port
  input  logic [PF_IDX_W-1:0] rd_idx_i,           // Fetch word index
  output logic [M1_DW-1:0]    rd_data_o           // Word at fetch index
);

  // Storage, contents undefined until loaded
  logic [M1_DW-1:0] mem_q [PF_DEPTH];

  // Synchronous load
  always_ff @(posedge sys_clock_i) begin
    if (pf_load_i) begin
      mem_q[pf_idx_i] <= pf_data_i;
    end
  end

  // Asynchronous read so a hit completes in the request cycle
  assign rd_data_o = mem_q[rd_idx_i];

endmodule

/* verilog/m1_subsys.sv */
module m1_subsys import m1_pkg::*; (
  // System
  input  logic              sys_clock_i,          // System clock
  input  logic              reset_i,              // Sync reset, active high

  // Config port
  input  logic              cfg_we_i,             // Config write strobe
  input  logic [CFG_AW-1:0] cfg_addr_i,           // Config register code
  input  logic [M1_DW-1:0]  cfg_wdata_i,          // Config write data

  // Instruction request
  input  logic              imem_read_i,
  input  logic [M1_AW-1:0]  imem_addr_i,
  output logic              imem_done_o,
  output logic [M1_DW-1:0]  imem_data_o,

  // Data request
  input  logic              dmem_read_i,
  input  logic              dmem_write_i,
  input  logic [M1_AW-1:0]  dmem_addr_i,
  input  logic [M1_DW-1:0]  dmem_data_i,
  input  logic [M1_SW-1:0]  dmem_sel_i,
  output logic              dmem_done_o,
  output logic [M1_DW-1:0]  dmem_data_o
);

  // Config to MMU
  logic                      win_en;
  logic [M1_AW-1:PF_WIN_LSB] win_base;

  // Config to buffer load port
  logic                      pf_load;
  logic [PF_IDX_W-1:0]       pf_idx;
  logic [M1_DW-1:0]          pf_data;

  // MMU to buffer read port
  logic [PF_IDX_W-1:0]       pf_rd_idx;
  logic [M1_DW-1:0]          pf_rd_data;

  // Wishbone between MMU and slave RAM
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [M1_AW-1:0]          wb_adr;
  logic [M1_DW-1:0]          wb_dat_m2s;          // Master write data
  logic [M1_SW-1:0]          wb_sel;
  logic                      wb_ack;
  logic [M1_DW-1:0]          wb_dat_s2m;          // Slave read data

  m1_mmu_cfg m1_mmu_cfg_i (
    .sys_clock_i (sys_clock_i),
    .reset_i     (reset_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .win_en_o    (win_en),
    .win_base_o  (win_base),
    .pf_load_o   (pf_load),
    .pf_idx_o    (pf_idx),
    .pf_data_o   (pf_data)
  );

  m1_prefetch_buf m1_prefetch_buf_i (
    .sys_clock_i (sys_clock_i),
    .pf_load_i   (pf_load),
    .pf_idx_i    (pf_idx),
    .pf_data_i   (pf_data),
    .rd_idx_i    (pf_rd_idx),
    .rd_data_o   (pf_rd_data)
  );

  m1_mmu m1_mmu_i (
    .sys_clock_i  (sys_clock_i),
    .reset_i      (reset_i),
    .win_en_i     (win_en),
    .win_base_i   (win_base),
    .imem_read_i  (imem_read_i),
    .imem_addr_i  (imem_addr_i),
    .imem_done_o  (imem_done_o),
    .imem_data_o  (imem_data_o),
    .dmem_read_i  (dmem_read_i),
    .dmem_write_i (dmem_write_i),
    .dmem_addr_i  (dmem_addr_i),
    .dmem_data_i  (dmem_data_i),
    .dmem_sel_i   (dmem_sel_i),
    .dmem_done_o  (dmem_done_o),
    .dmem_data_o  (dmem_data_o),
    .pf_rd_idx_o  (pf_rd_idx),
    .pf_rd_data_i (pf_rd_data),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_we_o      (wb_we),
    .wb_adr_o     (wb_adr),
    .wb_dat_o     (wb_dat_m2s),
    .wb_sel_o     (wb_sel),
    .wb_ack_i     (wb_ack),
    .wb_dat_i     (wb_dat_s2m)
  );

  // Stand-in for external memory
  m1_wb_mem m1_wb_mem_i (
    .sys_clock_i (sys_clock_i),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_m2s),
    .wb_sel_i    (wb_sel),
    .wb_ack_o    (wb_ack),
    .wb_dat_o    (wb_dat_s2m)
  );

endmodule

/* verilog/m1_wb_mem.sv */
module m1_wb_mem import m1_pkg::*; (
  // System
  input  logic             sys_clock_i,           // System clock
  input  logic             reset_i,               // Sync reset, active high

  // Wishbone slave
  input  logic             wb_cyc_i,              // Cycle
  input  logic             wb_stb_i,              // Strobe
  input  logic             wb_we_i,               // Write enable
  input  logic [M1_AW-1:0] wb_adr_i,              // Byte address
  input  logic [M1_DW-1:0] wb_dat_i,              // Write data
  input  logic [M1_SW-1:0] wb_sel_i,              // Byte selects
  output logic             wb_ack_o,              // Acknowledge, one cycle
  output logic [M1_DW-1:0] wb_dat_o               // Read data, valid with ack
);

  // Word storage, not reset
  logic [M1_DW-1:0] mem_q [EXT_DEPTH];

  logic [WB_CNT_W-1:0]  cnt_q;                    // Strobe cycles seen so far
  logic                 ack_q;
  logic [M1_DW-1:0]     rdata_q;                  // Read word captured for ack
  logic [EXT_IDX_W-1:0] idx;                      // Word index, bits [11:2]
  logic                 req;                      // Live request not yet acked
  logic                 ack_set;                  // Last wait cycle

  assign idx = wb_adr_i[EXT_IDX_W+1:2];
  assign req = wb_cyc_i && wb_stb_i && !ack_q;

  // Ack raised WB_ACK_DELAY cycles after the first strobe cycle
  assign ack_set = req && (cnt_q == WB_CNT_W'(WB_ACK_DELAY - 1));

  always_ff @(posedge sys_clock_i) begin
    if (reset_i) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else if (ack_q) begin
      cnt_q <= '0;                                // Ack cycle forces a gap
      ack_q <= 1'b0;
    end else if (ack_set) begin
      ack_q <= 1'b1;
    end else if (req) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Read data sampled as ack is set, held through the ack cycle
  always_ff @(posedge sys_clock_i) begin
    if (ack_set) begin
      rdata_q <= mem_q[idx];
    end
  end

  // Byte-lane write on the ack edge
  always_ff @(posedge sys_clock_i) begin
    if (ack_q && wb_we_i) begin
      for (int b = 0; b < M1_SW; b++) begin
        if (wb_sel_i[b]) begin
          mem_q[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
        end
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

endmodule
